/* pet_bus_pkg.sv */
/*
 * Shared bus definitions: address map, slot phase numbers,
 * host command and address decode structs
 */
package pet_bus_pkg;

    localparam int unsigned ADDR_W = 17;                        // Bus address width

    // CPU memory map
    localparam logic [ADDR_W-1:0] VRAM_BASE = 17'h0_8000;       // Video RAM, mirrored
    localparam logic [ADDR_W-1:0] VRAM_LAST = 17'h0_8FFF;
    localparam logic [ADDR_W-1:0] ROM_BASE  = 17'h0_9000;       // Write protected from here up
    localparam logic [ADDR_W-1:0] IO_BASE   = 17'h0_E800;       // 256 byte I/O page
    localparam logic [ADDR_W-1:0] PIA1_BASE = 17'h0_E810;       // 16 bytes per device
    localparam logic [ADDR_W-1:0] PIA2_BASE = 17'h0_E820;
    localparam logic [ADDR_W-1:0] VIA_BASE  = 17'h0_E840;

    localparam logic [ADDR_W-1:0] KBD_PORT_A = 17'h0_E810;      // Row select written by CPU
    localparam logic [ADDR_W-1:0] KBD_PORT_B = 17'h0_E812;      // Column read, intercepted

    // Host-only registers, bit 16 keeps them off the SRAM
    localparam logic [ADDR_W-1:0] KBD_ROW_BASE = 17'h1_E800;
    localparam logic [ADDR_W-1:0] CTL_REG_ADDR = 17'h1_E880;
    localparam int unsigned       KBD_ROWS     = 10;

    // Phase numbers within one 1 MHz CPU cycle
    localparam int unsigned PHASES         = 16;
    localparam logic [3:0]  SPI_SLOT_FIRST = 4'd2;
    localparam logic [3:0]  SPI_SLOT_LAST  = 4'd3;
    localparam logic [3:0]  CPU_SLOT_FIRST = 4'd8;              // Also rising edge of clk_cpu
    localparam logic [3:0]  CPU_WE_FIRST   = 4'd12;
    localparam logic [3:0]  CPU_WE_LAST    = 4'd14;

    typedef struct packed {
        logic              rw_n;                                // 1 = host reads
        logic [ADDR_W-1:0] addr;
        logic [7:0]        data;                                // Write data, unused on reads
    } spi_cmd_t;

    typedef struct packed {
        logic ram_en;
        logic io_en;
        logic pia1_en;
        logic pia2_en;
        logic via_en;
        logic readonly;                                         // ROM area, writes blocked
        logic mirrored;                                         // A11/A10 forced low
    } bus_decode_t;

endpackage

/* spi_bridge.sv */
/*
 * SPI mode 0 slave for host bus commands: byte assembly,
 * pending command hold and read data shift-out
 */
`timescale 1ns/100ps

module spi_bridge (
    input  logic                  clk_16_i,
    input  logic                  rst_n_i,
    input  logic                  spi_sclk_i,
    input  logic                  spi_cs_ni,
    input  logic                  spi_rx_i,
    output logic                  spi_tx_o,
    input  logic [7:0]            spi_rd_data_i,   // Byte captured by the bus for reads
    input  logic                  spi_done_i,      // Bus slot finished
    output pet_bus_pkg::spi_cmd_t spi_cmd_o,
    output logic                  spi_valid_o,     // Command pending
    output logic                  spi_ready_no     // Low once the command has completed
);
    logic [2:0]                     sclk_q;        // Sync stages plus edge history
    logic [2:0]                     cs_q;
    logic [1:0]                     rx_q;
    logic [2:0]                     bit_cnt;
    logic [1:0]                     byte_cnt;
    logic [7:0]                     rx_shift;
    logic [7:0]                     tx_shift;
    logic                           stage_rw_n;
    logic [pet_bus_pkg::ADDR_W-1:0] stage_addr;
    pet_bus_pkg::spi_cmd_t          cmd_q;
    logic                           valid_q;
    logic                           ready_nq;

    wire sclk_rise = sclk_q[1] & ~sclk_q[2];
    wire sclk_fall = ~sclk_q[1] & sclk_q[2];
    wire cs_rise   = cs_q[1] & ~cs_q[2];           // End of transfer
    wire [7:0] rx_byte = {rx_shift[6:0], rx_q[1]}; // Byte as of this SCLK edge

    always_ff @(posedge clk_16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sclk_q     <= 3'b000;
            cs_q       <= 3'b111;                  // Idle deselected
            rx_q       <= 2'b00;
            bit_cnt    <= 3'd0;
            byte_cnt   <= 2'd0;
            rx_shift   <= 8'h00;
            tx_shift   <= 8'h00;
            stage_rw_n <= 1'b1;
            stage_addr <= '0;
            cmd_q      <= '0;
            valid_q    <= 1'b0;
            ready_nq   <= 1'b1;
        end else begin
            sclk_q <= {sclk_q[1:0], spi_sclk_i};
            cs_q   <= {cs_q[1:0], spi_cs_ni};
            rx_q   <= {rx_q[0], spi_rx_i};

            if (spi_done_i) valid_q <= 1'b0;       // Low the cycle after done

            if (spi_done_i) ready_nq <= 1'b0;
            else if (cs_rise) ready_nq <= 1'b1;

            if (cs_q[1]) begin
                bit_cnt  <= 3'd0;                  // Restart framing while deselected
                byte_cnt <= 2'd0;
            end else if (sclk_rise) begin
                rx_shift <= rx_byte;
                bit_cnt  <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    byte_cnt <= byte_cnt + 2'd1;
                    case (byte_cnt)
                        2'd0: begin
                            stage_rw_n     <= rx_byte[7];
                            stage_addr[16] <= rx_byte[0];
                        end
                        2'd1: stage_addr[15:8] <= rx_byte;
                        2'd2: begin
                            stage_addr[7:0] <= rx_byte;
                            if (stage_rw_n && !valid_q) begin  // Read pends after address
                                cmd_q   <= {1'b1, stage_addr[16:8], rx_byte, 8'h00};
                                valid_q <= 1'b1;
                            end
                        end
                        default: begin
                            if (!stage_rw_n && !valid_q) begin // Write pends after data
                                cmd_q   <= {1'b0, stage_addr, rx_byte};
                                valid_q <= 1'b1;
                            end
                        end
                    endcase
                end
            end else if (sclk_fall) begin
                // First falling edge of the dummy byte presents the read MSB
                if (byte_cnt == 2'd3 && bit_cnt == 3'd0 && stage_rw_n)
                    tx_shift <= spi_rd_data_i;
                else
                    tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end
    end

    assign spi_tx_o     = tx_shift[7];
    assign spi_cmd_o    = cmd_q;
    assign spi_valid_o  = valid_q;
    assign spi_ready_no = ready_nq;

    // Bus side samples the command across the whole slot
    a_cmd_stable: assert property (@(posedge clk_16_i) disable iff (!rst_n_i)
        (spi_valid_o && $past(spi_valid_o)) |-> $stable(spi_cmd_o));

endmodule

/* bus_timing.sv */
/*
 * Phase counter, CPU clock and fixed host/CPU slot arbiter
 */
`timescale 1ns/100ps

module bus_timing (
    input  logic       clk_16_i,
    input  logic       rst_n_i,
    input  logic       spi_valid_i,     // Host command pending
    input  logic       cpu_ready_i,     // CPU allowed to run
    output logic       clk_cpu_o,
    output logic       spi_en_o,        // Host owns the bus
    output logic       spi_done_o,      // One cycle after the host slot
    output logic       cpu_en_o,        // CPU owns the bus
    output logic [3:0] phase_o
);
    logic [3:0] phase_q;
    logic       spi_grant_q;            // Host slot granted this cycle
    logic       cpu_grant_q;

    always_ff @(posedge clk_16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase_q     <= 4'd0;
            spi_grant_q <= 1'b0;
            cpu_grant_q <= 1'b0;
        end else begin
            if (phase_q == 4'(pet_bus_pkg::PHASES - 1)) phase_q <= 4'd0;
            else phase_q <= phase_q + 4'd1;

            if (phase_q == 4'd0) spi_grant_q <= spi_valid_i;  // Sampled at phase 0
            if (phase_q == pet_bus_pkg::CPU_SLOT_FIRST - 4'd1)
                cpu_grant_q <= cpu_ready_i;                   // Held through the CPU half
        end
    end

    assign clk_cpu_o  = (phase_q >= pet_bus_pkg::CPU_SLOT_FIRST);
    assign spi_en_o   = spi_grant_q && (phase_q >= pet_bus_pkg::SPI_SLOT_FIRST)
                                    && (phase_q <= pet_bus_pkg::SPI_SLOT_LAST);
    assign spi_done_o = spi_grant_q && (phase_q == pet_bus_pkg::SPI_SLOT_LAST + 4'd1);
    assign cpu_en_o   = cpu_grant_q && clk_cpu_o;
    assign phase_o    = phase_q;

    // Both requesters drive the shared SRAM bus
    a_one_owner: assert property (@(posedge clk_16_i) disable iff (!rst_n_i)
        !(spi_en_o && cpu_en_o));

endmodule

/* address_decoder.sv */
/*
 * CPU memory map decode into device enables and access flags
 */
`timescale 1ns/100ps

module address_decoder (
    input  logic [pet_bus_pkg::ADDR_W-1:0] cpu_addr_i,
    output pet_bus_pkg::bus_decode_t       decode_o
);
    logic io_page;

    assign io_page = (cpu_addr_i[16:8] == pet_bus_pkg::IO_BASE[16:8]);   // E800-E8FF

    always_comb begin
        decode_o          = '0;
        decode_o.io_en    = io_page;
        decode_o.ram_en   = !io_page;                                     // RAM and ROM elsewhere
        decode_o.pia1_en  = (cpu_addr_i[16:4] == pet_bus_pkg::PIA1_BASE[16:4]);
        decode_o.pia2_en  = (cpu_addr_i[16:4] == pet_bus_pkg::PIA2_BASE[16:4]);
        decode_o.via_en   = (cpu_addr_i[16:4] == pet_bus_pkg::VIA_BASE[16:4]);
        decode_o.readonly = (cpu_addr_i >= pet_bus_pkg::ROM_BASE) && !io_page;
        decode_o.mirrored = (cpu_addr_i >= pet_bus_pkg::VRAM_BASE)
                         && (cpu_addr_i <= pet_bus_pkg::VRAM_LAST);       // 1 KB video mirror
    end

endmodule

/* pi_register_file.sv */
/*
 * Host keyboard matrix, CPU row select latch, keyboard read
 * intercept and CPU control register
 */
`timescale 1ns/100ps

module pi_register_file (
    input  logic                           clk_16_i,
    input  logic                           rst_n_i,
    input  pet_bus_pkg::spi_cmd_t          spi_cmd_i,
    input  logic                           spi_en_i,
    input  logic [pet_bus_pkg::ADDR_W-1:0] cpu_addr_i,
    input  logic [7:0]                     cpu_data_i,
    input  logic                           cpu_rw_n_i,
    input  logic                           cpu_en_i,
    input  logic [3:0]                     phase_i,
    input  pet_bus_pkg::bus_decode_t       decode_i,
    output logic [7:0]                     reg_rd_data_o,   // Host read of these registers
    output logic                           kbd_en_o,        // Keyboard read intercept
    output logic [7:0]                     kbd_data_o,
    output logic                           cpu_res_no,
    output logic                           cpu_ready_o
);
    logic [7:0] kbd_rows [pet_bus_pkg::KBD_ROWS];           // 0 bits are pressed keys
    logic [3:0] row_sel_q;
    logic [1:0] ctl_q;                                      // Bit 0 reset, bit 1 ready
    logic       host_row_hit;
    logic       host_ctl_hit;

    assign host_row_hit = (spi_cmd_i.addr[16:4] == pet_bus_pkg::KBD_ROW_BASE[16:4])
                       && (spi_cmd_i.addr[3:0] < pet_bus_pkg::KBD_ROWS);
    assign host_ctl_hit = (spi_cmd_i.addr == pet_bus_pkg::CTL_REG_ADDR);

    always_ff @(posedge clk_16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < pet_bus_pkg::KBD_ROWS; i++) kbd_rows[i] <= 8'hFF;
            row_sel_q <= 4'd0;
            ctl_q     <= 2'b01;                             // CPU held in reset, not ready
        end else begin
            if (spi_en_i && !spi_cmd_i.rw_n) begin
                if (host_row_hit) kbd_rows[spi_cmd_i.addr[3:0]] <= spi_cmd_i.data;
                if (host_ctl_hit) ctl_q <= spi_cmd_i.data[1:0];
            end
            // Latch row select late in the write, PIA1 still sees the write
            if (cpu_en_i && !cpu_rw_n_i && phase_i == pet_bus_pkg::CPU_WE_LAST
                    && cpu_addr_i == pet_bus_pkg::KBD_PORT_A)
                row_sel_q <= cpu_data_i[3:0];
        end
    end

    always_comb begin
        if (host_ctl_hit) reg_rd_data_o = {6'b0, ctl_q};
        else if (host_row_hit) reg_rd_data_o = kbd_rows[spi_cmd_i.addr[3:0]];
        else reg_rd_data_o = 8'hFF;                         // Unmapped host register
    end

    assign kbd_en_o   = cpu_en_i && cpu_rw_n_i && decode_i.pia1_en
                     && (cpu_addr_i == pet_bus_pkg::KBD_PORT_B);
    assign kbd_data_o = (row_sel_q < pet_bus_pkg::KBD_ROWS) ? kbd_rows[row_sel_q] : 8'hFF;
    assign cpu_res_no  = !ctl_q[0];
    assign cpu_ready_o = ctl_q[1];

endmodule

/* bus_steering.sv */
/*
 * Bus owner mux, SRAM strobes, device chip selects
 * and host read data capture
 */
`timescale 1ns/100ps

module bus_steering (
    input  logic                           clk_16_i,
    input  logic                           rst_n_i,
    input  pet_bus_pkg::spi_cmd_t          spi_cmd_i,
    input  logic                           spi_en_i,
    input  logic                           cpu_en_i,
    input  logic [3:0]                     phase_i,
    input  logic                           cpu_rw_n_i,
    input  logic [pet_bus_pkg::ADDR_W-1:0] cpu_addr_i,
    input  logic [7:0]                     cpu_data_i,
    input  pet_bus_pkg::bus_decode_t       decode_i,
    input  logic                           kbd_en_i,
    input  logic [7:0]                     kbd_data_i,
    input  logic [7:0]                     reg_rd_data_i,
    input  logic [7:0]                     ram_data_i,
    output logic [pet_bus_pkg::ADDR_W-1:0] ram_addr_o,
    output logic [7:0]                     ram_data_o,
    output logic                           ram_ce_no,
    output logic                           ram_oe_no,
    output logic                           ram_we_no,
    output logic                           pia1_cs_no,
    output logic                           pia2_cs_no,
    output logic                           via_cs_no,
    output logic                           io_oe_no,
    output logic [7:0]                     cpu_data_o,
    output logic [7:0]                     spi_rd_data_o
);
    logic       spi_ram;                            // Host access goes to SRAM
    logic       spi_rd_en;
    logic       spi_wr_en;
    logic       cpu_rd_en;
    logic       cpu_wr_en;
    logic       cpu_we_win;                         // CPU write strobe window
    logic [7:0] spi_rd_q;

    assign spi_ram    = spi_en_i && !spi_cmd_i.addr[16];
    assign spi_rd_en  = spi_en_i &&  spi_cmd_i.rw_n;
    assign spi_wr_en  = spi_en_i && !spi_cmd_i.rw_n;
    assign cpu_rd_en  = cpu_en_i &&  cpu_rw_n_i;
    assign cpu_wr_en  = cpu_en_i && !cpu_rw_n_i;
    assign cpu_we_win = (phase_i >= pet_bus_pkg::CPU_WE_FIRST)
                     && (phase_i <= pet_bus_pkg::CPU_WE_LAST);

    always_comb begin
        if (spi_en_i) ram_addr_o = spi_cmd_i.addr;                      // Host sees all RAM
        else if (decode_i.mirrored) ram_addr_o = {cpu_addr_i[16:12], 2'b00, cpu_addr_i[9:0]};
        else ram_addr_o = cpu_addr_i;
    end

    assign ram_data_o = spi_wr_en ? spi_cmd_i.data : cpu_data_i;
    assign ram_ce_no  = !(spi_ram || (cpu_en_i && decode_i.ram_en));
    assign ram_oe_no  = !((spi_ram && spi_rd_en) || (cpu_rd_en && decode_i.ram_en));
    assign ram_we_no  = !((spi_ram && spi_wr_en)
                       || (cpu_wr_en && decode_i.ram_en && cpu_we_win && !decode_i.readonly));

    // Keyboard intercept hides the PIA1 read from the I/O bus
    assign pia1_cs_no = !(cpu_en_i && decode_i.pia1_en && !kbd_en_i);
    assign pia2_cs_no = !(cpu_en_i && decode_i.pia2_en);
    assign via_cs_no  = !(cpu_en_i && decode_i.via_en);
    assign io_oe_no   = !(cpu_en_i && decode_i.io_en && !kbd_en_i);
    assign cpu_data_o = kbd_en_i ? kbd_data_i : ram_data_i;

    always_ff @(posedge clk_16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            spi_rd_q <= 8'h00;
        end else if (spi_rd_en && phase_i == pet_bus_pkg::SPI_SLOT_LAST) begin // SRAM settled by now
            spi_rd_q <= spi_cmd_i.addr[16] ? reg_rd_data_i : ram_data_i;
        end
    end

    assign spi_rd_data_o = spi_rd_q;

    // SRAM would drive against the write data
    a_no_oe_we: assert property (@(posedge clk_16_i) disable iff (!rst_n_i)
        !(!ram_oe_no && !ram_we_no));

endmodule

/* pet_bus_top.sv */
/*
 * System bus controller top: SPI bridge, slot timing,
 * address decode, host registers and bus steering
 */
`timescale 1ns/100ps

module pet_bus_top (
    input  logic                           clk_16_i,
    input  logic                           rst_n_i,
    input  logic                           spi_sclk_i,
    input  logic                           spi_cs_ni,
    input  logic                           spi_rx_i,
    output logic                           spi_tx_o,
    output logic                           spi_ready_no,
    output logic                           clk_cpu_o,
    output logic                           cpu_res_no,
    output logic                           cpu_ready_o,
    output logic                           cpu_en_o,
    input  logic                           cpu_rw_n_i,
    input  logic [pet_bus_pkg::ADDR_W-1:0] cpu_addr_i,
    input  logic [7:0]                     cpu_data_i,
    output logic [7:0]                     cpu_data_o,
    output logic [pet_bus_pkg::ADDR_W-1:0] ram_addr_o,
    input  logic [7:0]                     ram_data_i,
    output logic [7:0]                     ram_data_o,
    output logic                           ram_ce_no,
    output logic                           ram_oe_no,
    output logic                           ram_we_no,
    output logic                           pia1_cs_no,
    output logic                           pia2_cs_no,
    output logic                           via_cs_no,
    output logic                           io_oe_no
);
    pet_bus_pkg::spi_cmd_t    spi_cmd;
    pet_bus_pkg::bus_decode_t decode;
    logic                     spi_valid;
    logic                     spi_en;
    logic                     spi_done;
    logic [7:0]               spi_rd_data;
    logic [3:0]               phase;
    logic [7:0]               reg_rd_data;
    logic                     kbd_en;
    logic [7:0]               kbd_data;

    spi_bridge spi_bridge (
        .clk_16_i(clk_16_i),           .rst_n_i(rst_n_i),
        .spi_sclk_i(spi_sclk_i),       .spi_cs_ni(spi_cs_ni),
        .spi_rx_i(spi_rx_i),           .spi_tx_o(spi_tx_o),
        .spi_rd_data_i(spi_rd_data),   .spi_done_i(spi_done),
        .spi_cmd_o(spi_cmd),           .spi_valid_o(spi_valid),
        .spi_ready_no(spi_ready_no)
    );

    bus_timing bus_timing (
        .clk_16_i(clk_16_i),           .rst_n_i(rst_n_i),
        .spi_valid_i(spi_valid),       .cpu_ready_i(cpu_ready_o),
        .clk_cpu_o(clk_cpu_o),         .spi_en_o(spi_en),
        .spi_done_o(spi_done),         .cpu_en_o(cpu_en_o),
        .phase_o(phase)
    );

    address_decoder address_decoder (
        .cpu_addr_i(cpu_addr_i),
        .decode_o(decode)
    );

    pi_register_file pi_register_file (
        .clk_16_i(clk_16_i),           .rst_n_i(rst_n_i),
        .spi_cmd_i(spi_cmd),           .spi_en_i(spi_en),
        .cpu_addr_i(cpu_addr_i),       .cpu_data_i(cpu_data_i),
        .cpu_rw_n_i(cpu_rw_n_i),       .cpu_en_i(cpu_en_o),
        .phase_i(phase),               .decode_i(decode),
        .reg_rd_data_o(reg_rd_data),   .kbd_en_o(kbd_en),
        .kbd_data_o(kbd_data),         .cpu_res_no(cpu_res_no),
        .cpu_ready_o(cpu_ready_o)
    );

    bus_steering bus_steering (
        .clk_16_i(clk_16_i),           .rst_n_i(rst_n_i),
        .spi_cmd_i(spi_cmd),           .spi_en_i(spi_en),
        .cpu_en_i(cpu_en_o),           .phase_i(phase),
        .cpu_rw_n_i(cpu_rw_n_i),       .cpu_addr_i(cpu_addr_i),
        .cpu_data_i(cpu_data_i),       .decode_i(decode),
        .kbd_en_i(kbd_en),             .kbd_data_i(kbd_data),
        .reg_rd_data_i(reg_rd_data),   .ram_data_i(ram_data_i),
        .ram_addr_o(ram_addr_o),       .ram_data_o(ram_data_o),
        .ram_ce_no(ram_ce_no),         .ram_oe_no(ram_oe_no),
        .ram_we_no(ram_we_no),         .pia1_cs_no(pia1_cs_no),
        .pia2_cs_no(pia2_cs_no),       .via_cs_no(via_cs_no),
        .io_oe_no(io_oe_no),           .cpu_data_o(cpu_data_o),
        .spi_rd_data_o(spi_rd_data)
    );

endmodule

/* tb_sram_model.sv */
/*
 * 128 KB asynchronous SRAM model with address-based fill,
 * write strobes sampled on the system clock
 */
`timescale 1ns/100ps

module tb_sram_model (
    input  logic                           clk_i,
    input  logic [pet_bus_pkg::ADDR_W-1:0] addr_i,
    input  logic [7:0]                     data_i,
    output logic [7:0]                     data_o,
    input  logic                           ce_ni,
    input  logic                           oe_ni,
    input  logic                           we_ni
);
    logic [7:0] mem [2**pet_bus_pkg::ADDR_W];

    initial begin
        logic [pet_bus_pkg::ADDR_W-1:0] fill;
        for (int a = 0; a < 2**pet_bus_pkg::ADDR_W; a++) begin
            fill   = a;
            mem[a] = fill[7:0] ^ fill[15:8] ^ {7'd0, fill[16]};  // Every address bit counts
        end
    end

    assign data_o = (!ce_ni && !oe_ni) ? mem[addr_i] : 8'hxx;  // Undriven bus reads as x

    always @(posedge clk_i) begin
        if (!ce_ni && !we_ni) mem[addr_i] <= data_i;
    end

endmodule

/* tb_pet_bus.sv */
/*
 * Testbench for the bus controller: SPI host master, CPU cycle
 * driver and pattern file checker
 */
`timescale 1ns/100ps

module tb_pet_bus;
    logic                           clk_16_i = 1'b0;
    logic                           rst_n_i = 1'b0;
    logic                           spi_sclk_i = 1'b0;
    logic                           spi_cs_ni = 1'b1;           // Host idle
    logic                           spi_rx_i = 1'b0;
    logic                           cpu_rw_n_i = 1'b1;
    logic [pet_bus_pkg::ADDR_W-1:0] cpu_addr_i = '0;
    logic [7:0]                     cpu_data_i = 8'h00;
    logic                           spi_tx_o;
    logic                           spi_ready_no;
    logic                           clk_cpu_o;
    logic                           cpu_res_no;
    logic                           cpu_ready_o;
    logic                           cpu_en_o;
    logic [7:0]                     cpu_data_o;
    logic [pet_bus_pkg::ADDR_W-1:0] ram_addr_o;
    logic [7:0]                     ram_data_i;
    logic [7:0]                     ram_data_o;
    logic                           ram_ce_no, ram_oe_no, ram_we_no;
    logic                           pia1_cs_no, pia2_cs_no, via_cs_no, io_oe_no;
    logic                           cpu_go = 1'b0;              // Host has set CPU ready

    pet_bus_top dut0 (.*);

    tb_sram_model sram (
        .clk_i(clk_16_i),    .addr_i(ram_addr_o),  .data_i(ram_data_o),
        .data_o(ram_data_i), .ce_ni(ram_ce_no),    .oe_ni(ram_oe_no),
        .we_ni(ram_we_no)
    );

    always #20 clk_16_i = ~clk_16_i;                            // 40 ns period

    task automatic report_timeout(input string what);
        $display("Timed out after 2000 cycles waiting for %s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // Control register bit 0 holds the CPU in reset and bit 1 lets it run
    task automatic check_cpu_control(input logic [1:0] ctl);
        check_value("cpu_res_no", {7'd0, cpu_res_no}, {7'd0, ~ctl[0]});
        check_value("cpu_ready_o", {7'd0, cpu_ready_o}, {7'd0, ctl[1]});
    endtask

    task automatic wait_spi_ready(input logic level);
        int n;
        n = 0;
        while (spi_ready_no !== level) begin
            if (n == 2000) report_timeout("spi_ready_no");
            @(negedge clk_16_i);
            n++;
        end
    endtask

    task automatic wait_cpu_clock(input logic level);
        int n;
        n = 0;
        while (clk_cpu_o !== level) begin
            if (n == 2000) report_timeout("clk_cpu_o");
            @(negedge clk_16_i);
            n++;
        end
    endtask

    // Mode 0 bit with MISO sampled just before the rising SCLK edge
    task automatic shift_spi_bit(input logic b, input logic hold, output logic miso);
        spi_rx_i <= b;
        repeat (32) @(posedge clk_16_i);
        miso = spi_tx_o;
        spi_sclk_i <= 1'b1;
        repeat (32) @(posedge clk_16_i);
        if (hold) wait_spi_ready(1'b0);                         // Command done on the bus
        @(posedge clk_16_i);
        spi_sclk_i <= 1'b0;
    endtask

    task automatic spi_transfer(input logic rw_n, input logic [16:0] addr,
                                input logic [7:0] data, output logic [7:0] rd);
        logic [31:0] frame;
        logic        miso;
        frame = {rw_n, 6'd0, addr, data};                       // Reads send a zero dummy byte
        rd    = 8'h00;
        @(posedge clk_16_i);
        spi_cs_ni <= 1'b0;
        for (int i = 31; i >= 0; i--) begin
            shift_spi_bit(frame[i], rw_n ? (i == 8) : (i == 0), miso);
            if (i < 8) rd[i] = miso;
        end
        repeat (32) @(posedge clk_16_i);
        spi_cs_ni <= 1'b1;
        wait_spi_ready(1'b1);
        repeat (32) @(posedge clk_16_i);
    endtask

    // One CPU bus cycle with inputs changing just after clk_cpu_o falls
    task automatic cpu_cycle(input logic rw_n, input logic [16:0] addr, input logic [7:0] wdata,
                             output logic [7:0] rdata, output logic [3:0] sel);
        int   n;
        logic seen;
        n     = 0;
        seen  = 1'b0;
        sel   = 4'h0;
        rdata = 8'h00;
        @(negedge clk_16_i);
        wait_cpu_clock(1'b1);
        wait_cpu_clock(1'b0);                                   // Phase 0
        @(posedge clk_16_i);
        cpu_rw_n_i <= rw_n;
        cpu_addr_i <= addr;
        cpu_data_i <= wdata;
        wait_cpu_clock(1'b1);                                   // CPU half begins
        while (clk_cpu_o === 1'b1) begin
            if (n == 2000) report_timeout("end of the CPU half cycle");
            seen  = seen | cpu_en_o;
            sel   = sel | ~{pia1_cs_no, pia2_cs_no, via_cs_no, io_oe_no};
            rdata = cpu_data_o;                                 // Last sample in phase 15
            @(negedge clk_16_i);
            n++;
        end
        @(posedge clk_16_i);
        cpu_rw_n_i <= 1'b1;                                     // Idle as reads
        check_value("cpu_en_o", {7'd0, seen}, 8'h01);
    endtask

    always @(negedge clk_16_i) begin
        if (rst_n_i && !cpu_go) check_value("cpu_en_o", {7'd0, cpu_en_o}, 8'h00);
    end

    initial begin
        int           fd;
        int           code;
        logic [7:0]   op;
        logic [16:0]  addr;
        logic [7:0]   data;
        logic [7:0]   rd;
        logic [3:0]   sel;
        logic [959:0] line;
        repeat (5) @(posedge clk_16_i);
        rst_n_i <= 1'b1;
        check_cpu_control(2'b01);                               // CPU in reset, not ready
        fd = $fopen("pet_bus_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file pet_bus_patterns.txt");
            $display("Checks failed");
            $fatal(1);
        end
        code = $fscanf(fd, " %c", op);
        while (code == 1) begin
            if (op == "#") begin
                code = $fgets(line, fd);                        // Column description
            end else begin
                code = $fscanf(fd, "%h %h", addr, data);
                case (op)
                    "W": begin
                        if (addr == pet_bus_pkg::CTL_REG_ADDR && data[1]) cpu_go = 1'b1;
                        spi_transfer(1'b0, addr, data, rd);
                        if (addr == pet_bus_pkg::CTL_REG_ADDR) check_cpu_control(data[1:0]);
                    end
                    "R": begin
                        spi_transfer(1'b1, addr, 8'h00, rd);
                        check_value("spi_tx_o read byte", rd, data);
                    end
                    "C": cpu_cycle(1'b0, addr, data, rd, sel);
                    "D": begin
                        cpu_cycle(1'b1, addr, 8'h00, rd, sel);
                        check_value("cpu_data_o", rd, data);
                    end
                    "S": begin
                        cpu_cycle(1'b1, addr, 8'h00, rd, sel);
                        check_value("device select mask", {4'h0, sel}, data);
                    end
                    default: begin
                        $display("Unknown opcode %c in the pattern file", op);
                        $display("Checks failed");
                        $fatal(1);
                    end
                endcase
            end
            code = $fscanf(fd, " %c", op);
        end
        $fclose(fd);
        $display("All checks passed");
        $finish;
    end

endmodule

/* pet_bus_patterns.txt */
# op addr data in hex. W host write, R host read checked against data
# C CPU write, D CPU read checked, S CPU read checked against select mask {pia1,pia2,via,io}
W 00123 A5
W 07FFE 3C
W 0C001 E1
W 0A000 99
R 00123 A5
R 07FFE 3C
R 0C001 E1
R 1E880 01
R 1E805 FF
W 1E880 02
R 1E880 02
C 00200 4B
C 01234 D2
D 00200 4B
D 01234 D2
R 01234 D2
C 08400 6E
R 08000 6E
D 08000 6E
C 0A000 11
R 0A000 99
S 0E821 05
S 0E841 03
W 1E803 5A
R 1E803 5A
C 0E810 03
D 0E812 5A
S 0E812 00

/* build.f */
pet_bus_pkg.sv
spi_bridge.sv
bus_timing.sv
address_decoder.sv
pi_register_file.sv
bus_steering.sv
pet_bus_top.sv
tb_sram_model.sv
tb_pet_bus.sv
